// ==== project.f ====
rtl/axi_wr_pkg.sv
rtl/dma_cfg_pkg.sv
rtl/axi_reg_slice.sv
rtl/dma_addr_gen.sv
rtl/dma_outstanding_limit.sv
rtl/dma_writer.sv
dv/axi_mem_model.sv
dv/tb_dma_writer.sv

// ==== dv/tb_dma_writer.sv ====
// --------------------------------------------------
// testbench for the DMA write engine
//   clock, reset, random transfers, stream driver
//   expected bursts, beats and memory image
//   AW, W, outstanding and memory checks
// --------------------------------------------------

`timescale 1ns/1ps

module tb_dma_writer
	import axi_wr_pkg::*, dma_cfg_pkg::*;
;

	localparam int n_xfers        = 20;
	localparam int max_words      = 64;
	localparam int mem_depth      = 1024;
	localparam int timeout_cycles = n_xfers * max_words * 8 + 1000;

	logic              aclk;
	logic              aresetn;
	logic              enable;
	logic              busy;
	dma_param_t        param;
	axi_aw_t           m_aw;
	logic              m_awvalid;
	logic              m_awready;
	axi_w_t            m_w;
	logic              m_wvalid;
	logic              m_wready;
	axi_b_t            m_b;
	logic              m_bvalid;
	logic              m_bready;
	logic [data_w-1:0] s_tdata;
	logic              s_tvalid;
	logic              s_tready;

	integer            seed;
	int                n_checks;
	int                n_errors;
	int                cycles;
	int                aw_cnt;
	int                b_cnt;
	int                b_expected;
	int                words_total;
	int                cur_limit;
	logic              t_fired;
	logic [data_w-1:0] stream_q [$];
	burst_cmd_t        exp_aw [$];
	axi_w_t            exp_w [$];
	logic [data_w-1:0] exp_mem [mem_depth];

	dma_writer uut (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.enable    (enable),
		.busy      (busy),
		.param     (param),
		.m_aw      (m_aw),
		.m_awvalid (m_awvalid),
		.m_awready (m_awready),
		.m_w       (m_w),
		.m_wvalid  (m_wvalid),
		.m_wready  (m_wready),
		.m_b       (m_b),
		.m_bvalid  (m_bvalid),
		.m_bready  (m_bready),
		.s_tdata   (s_tdata),
		.s_tvalid  (s_tvalid),
		.s_tready  (s_tready)
	);

	axi_mem_model #(.depth(mem_depth)) mem_i (
		.aclk    (aclk),
		.aresetn (aresetn),
		.aw      (m_aw),
		.awvalid (m_awvalid),
		.awready (m_awready),
		.w       (m_w),
		.wvalid  (m_wvalid),
		.wready  (m_wready),
		.b       (m_b),
		.bvalid  (m_bvalid),
		.bready  (m_bready)
	);

	always #5 aclk = ~aclk;

	// every address bit shows up in the word
	function automatic logic [data_w-1:0] fill_word(input int idx);
		return (32'(idx) * 32'h9e37_79b9) ^ {16'(idx), 16'hbeef};
	endfunction

	task automatic compare(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		n_checks++;
		if (expected !== actual) begin
			n_errors++;
			$display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// split into bursts, queue stream words and update the memory image
	task automatic build_expected(input dma_param_t p);
		int                remaining;
		int                beats;
		int                idx;
		int                j;
		int                k;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] word;
		burst_cmd_t        cmd;
		axi_w_t            beat;
		remaining = p.count;
		addr      = p.addr;
		while (remaining > 0) begin
			beats    = (remaining < int'(p.maxlen) + 1) ? remaining : int'(p.maxlen) + 1;
			cmd.addr = addr;
			cmd.len  = len_w'(beats - 1);
			exp_aw.push_back(cmd);
			b_expected++;
			for (j = 0; j < beats; j++) begin
				word = $random(seed);
				stream_q.push_back(word);
				beat.data = word;
				beat.strb = p.wstrb;
				beat.last = (j == beats - 1);
				exp_w.push_back(beat);
				idx = int'(addr >> 2) % mem_depth;
				for (k = 0; k < strb_w; k++) begin
					if (p.wstrb[k]) begin
						exp_mem[idx][8*k +: 8] = word[8*k +: 8];
					end
				end
				addr = addr + 4;
			end
			remaining = remaining - beats;
		end
		words_total += p.count;
	endtask

	// ---------------------------------------------
	// stream driver with random gaps
	always @(posedge aclk) begin
		#1;
		if (!s_tvalid || t_fired) begin
			t_fired = 1'b0;
			if (stream_q.size() > 0 && ($random(seed) & 3) != 0) begin
				s_tvalid = 1'b1;
				s_tdata  = stream_q[0];
			end else begin
				s_tvalid = 1'b0;
			end
		end
	end

	// ---------------------------------------------
	// bus monitor, sampled mid-cycle
	always @(negedge aclk) begin : monitor
		burst_cmd_t cmd;
		axi_w_t     beat;
		if (aresetn) begin
			if (s_tvalid && s_tready) begin
				void'(stream_q.pop_front());
				t_fired = 1'b1;
			end
			if (m_awvalid && m_awready) begin
				aw_cnt++;
				n_checks++;
				if (aw_cnt - b_cnt > cur_limit) begin
					n_errors++;
					$display("outstanding bursts %0d went above the limit %0d",
						aw_cnt - b_cnt, cur_limit);
				end
				if (exp_aw.size() == 0) begin
					n_errors++;
					$display("AW burst issued after all expected bursts");
				end else begin
					cmd = exp_aw.pop_front();
					compare("aw_addr", cmd.addr, m_aw.addr);
					compare("aw_len", cmd.len, m_aw.len);
					compare("aw_size", 3'd2, m_aw.size);
					compare("aw_burst", 2'b01, m_aw.burst);
					compare("aw_cache", 4'b0001, m_aw.cache);
					compare("aw_prot", 3'b000, m_aw.prot);
					compare("aw_id", 0, m_aw.id);
				end
			end
			if (m_wvalid && m_wready) begin
				if (exp_w.size() == 0) begin
					n_errors++;
					$display("W beat accepted after all expected beats");
				end else begin
					beat = exp_w.pop_front();
					compare("w_data", beat.data, m_w.data);
					compare("w_strb", beat.strb, m_w.strb);
					compare("w_last", beat.last, m_w.last);
				end
			end
			compare("bready", 1, m_bready);
			if (m_bvalid && m_bready) begin
				b_cnt++;
			end
		end
	end

	// run limit
	always @(posedge aclk) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			$display("timeout after %0d cycles, transfers did not complete", cycles);
			$display("%0d checks, %0d errors", n_checks, n_errors);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin : main
		dma_param_t p;
		integer     rnd;
		int         word_idx;
		int         i;
		int         x;
		aclk        = 1'b0;
		seed        = 32'h31b2_2698;
		n_checks    = 0;
		n_errors    = 0;
		cycles      = 0;
		aw_cnt      = 0;
		b_cnt       = 0;
		b_expected  = 0;
		words_total = 0;
		cur_limit   = 0;
		aresetn     = 1'b0;
		enable      = 1'b0;
		param       = '0;
		s_tdata     = '0;
		s_tvalid    = 1'b0;
		t_fired     = 1'b0;
		for (i = 0; i < mem_depth; i++) begin
			exp_mem[i]   = fill_word(i);
			mem_i.mem[i] = fill_word(i);
		end
		repeat (5) @(posedge aclk);
		#1 aresetn = 1'b1;

		@(negedge aclk);
		compare("reset_busy", 0, busy);
		compare("reset_awvalid", 0, m_awvalid);
		compare("reset_wvalid", 0, m_wvalid);
		compare("reset_tready", 0, s_tready);
		compare("reset_bready", 1, m_bready);

		for (x = 0; x < n_xfers; x++) begin
			rnd      = $random(seed);
			p.count  = cnt_w'((rnd & 63) + 1);
			rnd      = $random(seed);
			p.maxlen = len_w'(rnd & 15);
			rnd      = $random(seed);
			p.limit  = cnt_w'((rnd & 3) + 1);
			rnd      = $random(seed);
			p.wstrb  = strb_w'(($unsigned(rnd) % 15) + 1);
			// whole transfer stays inside the first page
			rnd      = $random(seed);
			word_idx = $unsigned(rnd) % (mem_depth - int'(p.count) + 1);
			p.addr   = addr_w'(word_idx) << 2;
			cur_limit = p.limit;
			build_expected(p);

			@(posedge aclk);
			#1;
			param  = p;
			enable = 1'b1;
			do @(negedge aclk); while (!busy);
			@(posedge aclk);
			#1 enable = 1'b0;
			do @(negedge aclk); while (busy || b_cnt != b_expected);
			if (exp_aw.size() != 0 || exp_w.size() != 0) begin
				n_errors++;
				$display("transfer %0d ended with %0d bursts and %0d beats never seen",
					x, exp_aw.size(), exp_w.size());
			end
		end

		for (i = 0; i < mem_depth; i++) begin
			compare($sformatf("mem[%0d]", i), exp_mem[i], mem_i.mem[i]);
		end
		compare("beat_count", words_total, mem_i.beat_count);

		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== dv/axi_mem_model.sv ====
// --------------------------------------------------
// AXI4 write slave backed by a word memory
//   random awready, wready and bvalid delays
//   byte writes under the strobe, beat counter
// --------------------------------------------------

`timescale 1ns/1ps

module axi_mem_model
	import axi_wr_pkg::*;
#(
	parameter int depth = 1024
) (
	input  logic    aclk,
	input  logic    aresetn,
	input  axi_aw_t aw,
	input  logic    awvalid,
	output logic    awready,
	input  axi_w_t  w,
	input  logic    wvalid,
	output logic    wready,
	output axi_b_t  b,
	output logic    bvalid,
	input  logic    bready
);

	logic [data_w-1:0] mem [depth];
	axi_aw_t           aw_q [$];
	logic              in_reset;
	logic              active;
	logic              b_done;
	logic [addr_w-1:0] cur_addr;
	int                beats_left;
	int                b_owed;
	int                beat_count;
	integer            seed;

	initial begin
		seed       = 32'h31b2_2698;
		in_reset   = 1'b1;
		active     = 1'b0;
		b_done     = 1'b0;
		b_owed     = 0;
		beat_count = 0;
		awready    = 1'b0;
		wready     = 1'b0;
		bvalid     = 1'b0;
		b.id       = aw_id;
		b.resp     = 2'b00;
	end

	// handshakes taken mid-cycle, they complete at the next rising edge
	always @(negedge aclk) begin : sample
		int idx;
		int i;
		in_reset = !aresetn;
		if (in_reset) begin
			aw_q.delete();
			active = 1'b0;
			b_owed = 0;
		end else begin
			if (awvalid && awready) begin
				aw_q.push_back(aw);
			end
			if (wvalid && wready) begin
				idx = int'(cur_addr >> 2) % depth;
				for (i = 0; i < strb_w; i++) begin
					if (w.strb[i]) begin
						mem[idx][8*i +: 8] = w.data[8*i +: 8];
					end
				end
				cur_addr = cur_addr + 4;
				beat_count++;
				beats_left--;
				if (beats_left == 0) begin
					active = 1'b0;
					b_owed++;
				end
			end
			if (bvalid && bready) begin
				b_owed--;
				b_done = 1'b1;
			end
		end
	end

	// ---------------------------------------------
	// ready and response drivers
	always @(posedge aclk) begin
		#1;
		if (in_reset) begin
			awready = 1'b0;
			wready  = 1'b0;
			bvalid  = 1'b0;
		end else begin
			// W is taken only once its burst address is known
			if (!active && aw_q.size() > 0) begin
				cur_addr   = aw_q[0].addr;
				beats_left = int'(aw_q[0].len) + 1;
				void'(aw_q.pop_front());
				active     = 1'b1;
			end
			awready = ($random(seed) & 3) != 0;
			wready  = active && (($random(seed) & 3) != 0);
			if (!bvalid || b_done) begin
				b_done = 1'b0;
				bvalid = (b_owed > 0) && (($random(seed) & 3) != 0);
			end
		end
	end

endmodule

// ==== rtl/dma_writer.sv ====
// --------------------------------------------------
// DMA write engine, stream to AXI4 write master
//   address generator and outstanding limiter
//   W beat formation with wlast from burst length
//   register slices on AW, W, command and B
// --------------------------------------------------

`timescale 1ns/1ps

module dma_writer
	import axi_wr_pkg::*, dma_cfg_pkg::*;
(
	input  logic              aclk,
	input  logic              aresetn,
	input  logic              enable,
	output logic              busy,
	input  dma_param_t        param,
	output axi_aw_t           m_aw,
	output logic              m_awvalid,
	input  logic              m_awready,
	output axi_w_t            m_w,
	output logic              m_wvalid,
	input  logic              m_wready,
	input  axi_b_t            m_b,
	input  logic              m_bvalid,
	output logic              m_bready,
	input  logic [data_w-1:0] s_tdata,
	input  logic              s_tvalid,
	output logic              s_tready
);

	// --------------------------------------------------
	// address generator and limiter
	// --------------------------------------------------

	logic             gen_busy;
	burst_cmd_t       gen_addr;
	logic             gen_addr_valid;
	logic             gen_addr_ready;
	logic [len_w-1:0] gen_len;
	logic             gen_len_valid;
	logic             gen_len_ready;

	axi_aw_t          aw_in;
	logic             aw_in_valid;
	logic             aw_in_ready;
	logic             aw_fire;
	logic             block;

	axi_b_t           b_q;
	logic             b_q_valid;
	logic             b_fire;

	dma_addr_gen u_addr_gen (
		.aclk         (aclk),
		.aresetn      (aresetn),
		.enable       (enable),
		.busy         (gen_busy),
		.param        (param),
		.m_addr       (gen_addr),
		.m_addr_valid (gen_addr_valid),
		.m_addr_ready (gen_addr_ready),
		.m_len        (gen_len),
		.m_len_valid  (gen_len_valid),
		.m_len_ready  (gen_len_ready)
	);

	// both sides of the address handshake held low while blocked
	assign aw_in_valid    = gen_addr_valid && !block;
	assign gen_addr_ready = aw_in_ready && !block;
	assign aw_fire        = aw_in_valid && aw_in_ready;

	// only responses to our own ID retire a burst
	assign b_fire = b_q_valid && (b_q.id == aw_id);

	dma_outstanding_limit u_limit (
		.aclk    (aclk),
		.aresetn (aresetn),
		.limit   (param.limit),
		.aw_fire (aw_fire),
		.b_fire  (b_fire),
		.block   (block)
	);

	always_comb begin
		aw_in.id    = aw_id;
		aw_in.addr  = gen_addr.addr;
		aw_in.len   = gen_addr.len;
		aw_in.size  = aw_size;
		aw_in.burst = aw_burst;
		aw_in.cache = aw_cache;
		aw_in.prot  = aw_prot;
	end

	axi_reg_slice #(.width($bits(axi_aw_t))) u_aw_slice (
		.aclk    (aclk),
		.aresetn (aresetn),
		.s_data  (aw_in),
		.s_valid (aw_in_valid),
		.s_ready (aw_in_ready),
		.m_data  (m_aw),
		.m_valid (m_awvalid),
		.m_ready (m_awready)
	);

	// B capture, never stalled so bready stays high
	axi_reg_slice #(.width($bits(axi_b_t))) u_b_slice (
		.aclk    (aclk),
		.aresetn (aresetn),
		.s_data  (m_b),
		.s_valid (m_bvalid),
		.s_ready (m_bready),
		.m_data  (b_q),
		.m_valid (b_q_valid),
		.m_ready (1'b1)
	);

	// --------------------------------------------------
	// W beats
	// --------------------------------------------------

	logic [len_w-1:0] cmd_len;
	logic             cmd_valid;
	logic             cmd_ready;
	logic             w_busy_q;
	logic [len_w-1:0] w_cnt_q;
	axi_w_t           w_in;
	logic             w_in_valid;
	logic             w_in_ready;
	logic             w_fire;

	axi_reg_slice #(.width(len_w)) u_cmd_slice (
		.aclk    (aclk),
		.aresetn (aresetn),
		.s_data  (gen_len),
		.s_valid (gen_len_valid),
		.s_ready (gen_len_ready),
		.m_data  (cmd_len),
		.m_valid (cmd_valid),
		.m_ready (cmd_ready)
	);

	assign cmd_ready = !w_busy_q;

	always_comb begin
		w_in.data = s_tdata;
		w_in.strb = param.wstrb;
		// counter holds beats left minus one
		w_in.last = w_busy_q ? (w_cnt_q == '0) : (cmd_len == '0);
	end

	assign w_in_valid = (w_busy_q || cmd_valid) && s_tvalid;
	assign s_tready   = (w_busy_q || cmd_valid) && w_in_ready;
	assign w_fire     = w_in_valid && w_in_ready;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			w_busy_q <= 1'b0;
		end else if (w_fire && w_in.last) begin
			w_busy_q <= 1'b0;
		end else if (cmd_valid && cmd_ready) begin
			w_busy_q <= 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (cmd_valid && cmd_ready) begin
			w_cnt_q <= w_fire ? cmd_len - len_w'(1) : cmd_len;
		end else if (w_fire) begin
			w_cnt_q <= w_cnt_q - len_w'(1);
		end
	end

	axi_reg_slice #(.width($bits(axi_w_t))) u_w_slice (
		.aclk    (aclk),
		.aresetn (aresetn),
		.s_data  (w_in),
		.s_valid (w_in_valid),
		.s_ready (w_in_ready),
		.m_data  (m_w),
		.m_valid (m_wvalid),
		.m_ready (m_wready)
	);

	// busy until the last wlast has left the W slice
	assign busy = gen_busy || w_busy_q || cmd_valid || m_awvalid || m_wvalid;

endmodule

// ==== rtl/dma_outstanding_limit.sv ====
// --------------------------------------------------
// outstanding burst limiter
//   counts bursts awaiting a B response
//   registered flag that blocks AW at the limit
// --------------------------------------------------

`timescale 1ns/1ps

module dma_outstanding_limit
	import dma_cfg_pkg::*;
(
	input  logic             aclk,
	input  logic             aresetn,
	input  logic [cnt_w-1:0] limit,
	input  logic             aw_fire,
	input  logic             b_fire,
	output logic             block
);

	logic [cnt_w-1:0] count_q;
	logic [cnt_w-1:0] count_next;
	logic             block_q;
	logic             block_next;

	always_comb begin
		count_next = count_q;
		if (aw_fire) begin
			count_next = count_next + cnt_w'(1);
		end
		if (b_fire) begin
			count_next = count_next - cnt_w'(1);
		end
		block_next = limit_enable && (count_next >= limit);
	end

	// flag rises only on an accepted address, so nothing is waiting behind it
	// it may fall in any cycle
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			count_q <= '0;
			block_q <= 1'b0;
		end else begin
			count_q <= count_next;
			if (aw_fire || !block_next) begin
				block_q <= block_next;
			end
		end
	end

	assign block = block_q;

endmodule

// ==== rtl/dma_addr_gen.sv ====
// --------------------------------------------------
// DMA burst address generator
//   splits a transfer into INCR bursts
//   issues an address and a beat-count command per burst
// --------------------------------------------------

`timescale 1ns/1ps

module dma_addr_gen
	import axi_wr_pkg::*, dma_cfg_pkg::*;
(
	input  logic             aclk,
	input  logic             aresetn,
	input  logic             enable,
	output logic             busy,
	input  dma_param_t       param,
	output burst_cmd_t       m_addr,
	output logic             m_addr_valid,
	input  logic             m_addr_ready,
	output logic [len_w-1:0] m_len,
	output logic             m_len_valid,
	input  logic             m_len_ready
);

	logic              busy_q;
	logic [addr_w-1:0] addr_q;
	logic [cnt_w-1:0]  remain_q;
	logic [len_w-1:0]  maxlen_q;
	logic              addr_valid_q;
	logic              len_valid_q;
	burst_cmd_t        cmd_q;

	logic [cnt_w-1:0]  max_beats;
	logic [cnt_w-1:0]  beats;
	logic              addr_pend;
	logic              len_pend;
	logic              start;
	logic              issue;

	// --------------------------------------------------
	// burst sizing
	// --------------------------------------------------

	always_comb begin
		max_beats = cnt_w'(maxlen_q) + cnt_w'(1);
		// last burst may be short
		beats     = (remain_q < max_beats) ? remain_q : max_beats;
	end

	// commands still waiting after this cycle
	assign addr_pend = addr_valid_q && !m_addr_ready;
	assign len_pend  = len_valid_q && !m_len_ready;

	assign start = !busy_q && enable;
	assign issue = busy_q && !addr_pend && !len_pend && (remain_q != '0);

	// --------------------------------------------------
	// control
	// --------------------------------------------------

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			busy_q       <= 1'b0;
			addr_valid_q <= 1'b0;
			len_valid_q  <= 1'b0;
		end else begin
			if (start) begin
				busy_q <= 1'b1;
			end else if (busy_q && !addr_pend && !len_pend && (remain_q == '0)) begin
				// both last commands accepted
				busy_q <= 1'b0;
			end
			addr_valid_q <= addr_pend || issue;
			len_valid_q  <= len_pend || issue;
		end
	end

	// --------------------------------------------------
	// transfer state and command payload
	// --------------------------------------------------

	always_ff @(posedge aclk) begin
		if (start) begin
			addr_q   <= param.addr;
			remain_q <= param.count;
			maxlen_q <= param.maxlen;
		end else if (issue) begin
			cmd_q.addr <= addr_q;
			cmd_q.len  <= len_w'(beats - cnt_w'(1));
			addr_q     <= addr_q + (addr_w'(beats) << aw_size);
			remain_q   <= remain_q - beats;
		end
	end

	assign busy         = busy_q;
	assign m_addr       = cmd_q;
	assign m_addr_valid = addr_valid_q;
	assign m_len        = cmd_q.len;
	assign m_len_valid  = len_valid_q;

endmodule

// ==== rtl/axi_reg_slice.sv ====
// --------------------------------------------------
// valid/ready register slice
//   main register plus skid register
//   registered ready at full throughput
// --------------------------------------------------

`timescale 1ns/1ps

module axi_reg_slice #(
	parameter int width = 8
) (
	input  logic             aclk,
	input  logic             aresetn,
	input  logic [width-1:0] s_data,
	input  logic             s_valid,
	output logic             s_ready,
	output logic [width-1:0] m_data,
	output logic             m_valid,
	input  logic             m_ready
);

	logic [width-1:0] main_q;
	logic [width-1:0] skid_q;
	logic             main_valid_q;
	logic             skid_valid_q;
	logic             out_free;
	logic             s_fire;

	// main register can take a new word this cycle
	assign out_free = m_ready || !main_valid_q;
	assign s_fire   = s_valid && s_ready;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			main_valid_q <= 1'b0;
			skid_valid_q <= 1'b0;
		end else if (out_free) begin
			// skid drains first
			main_valid_q <= skid_valid_q || s_fire;
			skid_valid_q <= 1'b0;
		end else if (s_fire) begin
			skid_valid_q <= 1'b1;
		end
	end

	always_ff @(posedge aclk) begin
		if (out_free) begin
			main_q <= skid_valid_q ? skid_q : s_data;
		end else if (s_fire) begin
			skid_q <= s_data;
		end
	end

	assign s_ready = !skid_valid_q;
	assign m_valid = main_valid_q;
	assign m_data  = main_q;

endmodule

// ==== rtl/dma_cfg_pkg.sv ====
// --------------------------------------------------
// DMA side definitions
//   word count width and limiter switch
//   transfer parameters and burst command
// --------------------------------------------------

package dma_cfg_pkg;

	import axi_wr_pkg::*;

	// word count, one word per beat
	localparam int cnt_w = addr_w - int'(aw_size);

	// outstanding burst limiter on
	localparam logic limit_enable = 1'b1;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [cnt_w-1:0]  count;
		logic [len_w-1:0]  maxlen;
		logic [strb_w-1:0] wstrb;
		logic [cnt_w-1:0]  limit;
	} dma_param_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [len_w-1:0]  len;
	} burst_cmd_t;

endpackage

// ==== rtl/axi_wr_pkg.sv ====
// --------------------------------------------------
// AXI4 write channel definitions
//   bus widths and fixed AW attribute values
//   AW, W and B channel payload structs
// --------------------------------------------------

package axi_wr_pkg;

	// --------------------------------------------------
	// widths
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int strb_w = data_w / 8;
	// burst length field holds beats-1
	localparam int len_w  = 8;
	localparam int id_w   = 6;

	// --------------------------------------------------
	// fixed AW attributes
	// 4 bytes per beat
	localparam logic [2:0]      aw_size  = 3'd2;
	localparam logic [1:0]      aw_burst = 2'b01;
	localparam logic [3:0]      aw_cache = 4'b0001;
	localparam logic [2:0]      aw_prot  = 3'b000;
	localparam logic [id_w-1:0] aw_id    = '0;

	// --------------------------------------------------
	// channel payloads
	typedef struct packed {
		logic [id_w-1:0]   id;
		logic [addr_w-1:0] addr;
		logic [len_w-1:0]  len;
		logic [2:0]        size;
		logic [1:0]        burst;
		logic [3:0]        cache;
		logic [2:0]        prot;
	} axi_aw_t;

	typedef struct packed {
		logic [data_w-1:0] data;
		logic [strb_w-1:0] strb;
		logic              last;
	} axi_w_t;

	typedef struct packed {
		logic [id_w-1:0] id;
		logic [1:0]      resp;
	} axi_b_t;

endpackage
